//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= uart_str_link.f
TOP       ?= tb_uart_str_link
SEED      ?= 1
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf $(OBJ_DIR)

//--- src/uart_baud_timer.sv
`timescale 1ns/1ps
`default_nettype none

// uart baud timer.
// gives one tick per bit period while run is high, or a half period
// first when half_start is set as the run begins.

module uart_baud_timer (
	input  wire  sys_clk,
	input  wire  sys_rst_n,
	input  wire  run,
	input  wire  half_start,
	output logic tick
);

	import uart_str_pkg::*;

	logic [baud_cnt_w-1:0] cnt;
	logic                  active;

	// the first cycle of a run only loads, so the first count is two short.
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			cnt    <= '0;
			active <= 1'b0;
		end else if (!run) begin
			cnt    <= '0;
			active <= 1'b0;
		end else if (!active) begin
			active <= 1'b1;
			if (half_start) begin
				cnt <= baud_cnt_w'(clks_per_bit / 2 - 2);
			end else begin
				cnt <= baud_cnt_w'(clks_per_bit - 2);
			end
		end else if (cnt == '0) begin
			cnt <= baud_cnt_w'(clks_per_bit - 1);
		end else begin
			cnt <= cnt - 1'b1;
		end
	end

	assign tick = active && (cnt == '0);

	// users drop run only right after a tick, so a stale tick never shows.
	a_no_tick_idle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!run |-> !tick);

endmodule

`default_nettype wire

//--- src/uart_byte_rx.sv
`timescale 1ns/1ps
`default_nettype none

// uart byte receiver.
// synchronizes the line, finds the start edge and samples
// each bit near its middle. bytes with a low stop bit are dropped.

module uart_byte_rx (
	input  wire        sys_clk,
	input  wire        sys_rst_n,
	input  wire        uart_rx,
	output logic [7:0] byte_rx_data,
	output logic       byte_rx_valid
);

	import uart_str_pkg::*;

	logic       rx_meta;
	logic       rx_sync;
	logic       rx_prev;
	logic       start_edge;
	logic       busy;
	logic [3:0] bit_cnt;
	logic [7:0] shreg;
	logic       tick;

	uart_baud_timer uart_baud_timer_inst (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.run        (busy),
		.half_start (bit_cnt == 4'd0),
		.tick       (tick)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// line synchronizer and edge detect.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// resets to the idle high level so no false start is seen.
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= uart_rx;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	assign start_edge = rx_prev && !rx_sync;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// bit sampling.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// count 0 checks the start bit, 1..8 take data, 9 is the stop bit.
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy          <= 1'b0;
			bit_cnt       <= 4'd0;
			byte_rx_valid <= 1'b0;
		end else begin
			byte_rx_valid <= 1'b0;
			if (!busy) begin
				bit_cnt <= 4'd0;
				if (start_edge) begin
					busy <= 1'b1;
				end
			end else if (tick) begin
				if (bit_cnt == 4'd0) begin
					// line back high at mid start bit, a glitch.
					if (rx_sync) begin
						busy <= 1'b0;
					end else begin
						bit_cnt <= 4'd1;
					end
				end else if (bit_cnt == 4'd9) begin
					busy          <= 1'b0;
					bit_cnt       <= 4'd0;
					byte_rx_valid <= rx_sync;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end
		end
	end

	// lsb arrives first, so shift in from the top.
	always_ff @(posedge sys_clk) begin
		if (busy && tick && (bit_cnt != 4'd0) && (bit_cnt != 4'd9)) begin
			shreg <= {rx_sync, shreg[7:1]};
		end
	end

	assign byte_rx_data = shreg;

endmodule

`default_nettype wire

//--- src/uart_byte_tx.sv
`timescale 1ns/1ps
`default_nettype none

// uart byte transmitter.
// sends one 8n1 byte: start bit, data lsb first, one stop bit.

module uart_byte_tx (
	input  wire        sys_clk,
	input  wire        sys_rst_n,
	input  wire  [7:0] byte_tx_data,
	input  wire        byte_tx_start,
	output logic       uart_tx,
	output logic       byte_tx_done
);

	import uart_str_pkg::*;

	logic       busy;
	logic [3:0] bit_cnt;
	logic [7:0] shreg;
	logic       tick;

	uart_baud_timer uart_baud_timer_inst (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.run        (busy),
		.half_start (1'b0),
		.tick       (tick)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// bit sequencing.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// ticks 1..8 put out data, tick 9 the stop bit, tick 10 ends the byte.
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy    <= 1'b0;
			bit_cnt <= 4'd0;
			uart_tx <= 1'b1;
		end else if (!busy) begin
			if (byte_tx_start) begin
				busy    <= 1'b1;
				bit_cnt <= 4'd0;
				uart_tx <= 1'b0;
			end
		end else if (tick) begin
			if (bit_cnt == 4'd9) begin
				busy <= 1'b0;
			end else begin
				uart_tx <= shreg[0];
				bit_cnt <= bit_cnt + 1'b1;
			end
		end
	end

	// ones shift in behind the data and become the stop bit.
	always_ff @(posedge sys_clk) begin
		if (!busy && byte_tx_start) begin
			shreg <= byte_tx_data;
		end else if (busy && tick) begin
			shreg <= {1'b1, shreg[7:1]};
		end
	end

	assign byte_tx_done = busy && tick && (bit_cnt == 4'd9);

	// the handler starts a byte only when the line is free.
	a_start_idle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		byte_tx_start |-> !busy);

endmodule

`default_nettype wire

//--- src/uart_str_link.sv
`timescale 1ns/1ps
`default_nettype none

// uart string link top level.
// string handler joined to the byte transmitter and byte receiver.

module uart_str_link (
	input  wire                                sys_clk,
	input  wire                                sys_rst_n,
	input  wire  [uart_str_pkg::max_len*8-1:0] tx_string,
	input  wire  [uart_str_pkg::len_w-1:0]     tx_length,
	input  wire                                tx_req,
	output wire                                tx_busy,
	output wire                                tx_done,
	output wire  [uart_str_pkg::max_len*8-1:0] rx_string,
	output wire  [uart_str_pkg::len_w-1:0]     rx_length,
	output wire                                rx_busy,
	output wire                                rx_done,
	input  wire                                uart_rx,
	output wire                                uart_tx
);

	wire [7:0] byte_tx_data;
	wire       byte_tx_start;
	wire       byte_tx_done;
	wire [7:0] byte_rx_data;
	wire       byte_rx_valid;

	uart_string_handle uart_string_handle_inst (
		.sys_clk       (sys_clk),
		.sys_rst_n     (sys_rst_n),
		.tx_string     (tx_string),
		.tx_length     (tx_length),
		.tx_req        (tx_req),
		.tx_busy       (tx_busy),
		.tx_done       (tx_done),
		.rx_string     (rx_string),
		.rx_length     (rx_length),
		.rx_busy       (rx_busy),
		.rx_done       (rx_done),
		.byte_tx_data  (byte_tx_data),
		.byte_tx_start (byte_tx_start),
		.byte_tx_done  (byte_tx_done),
		.byte_rx_data  (byte_rx_data),
		.byte_rx_valid (byte_rx_valid)
	);

	uart_byte_tx uart_byte_tx_inst (
		.sys_clk       (sys_clk),
		.sys_rst_n     (sys_rst_n),
		.byte_tx_data  (byte_tx_data),
		.byte_tx_start (byte_tx_start),
		.uart_tx       (uart_tx),
		.byte_tx_done  (byte_tx_done)
	);

	uart_byte_rx uart_byte_rx_inst (
		.sys_clk       (sys_clk),
		.sys_rst_n     (sys_rst_n),
		.uart_rx       (uart_rx),
		.byte_rx_data  (byte_rx_data),
		.byte_rx_valid (byte_rx_valid)
	);

endmodule

`default_nettype wire

//--- src/uart_str_pkg.sv
`default_nettype none

// uart string link package.
// line timing, frame marker, string size and the handler state types.

package uart_str_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// line timing.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// system clocks per uart bit, kept small for short runs.
	localparam int clks_per_bit = 8;
	localparam int baud_cnt_w = $clog2(clks_per_bit);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// string framing.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// byte i of a string lives in bits 8i+7 down to 8i.
	localparam int max_len = 16;
	localparam int len_w = 5;

	// ascii "&", two in a row open or close a frame.
	localparam logic [7:0] frame_mark = 8'h26;

	typedef enum logic [2:0] {
		tx_idle,
		tx_open1,
		tx_open2,
		tx_body,
		tx_close1,
		tx_close2,
		tx_finish
	} tx_state_t;

	typedef enum logic [2:0] {
		rx_hunt,
		rx_open2,
		rx_body,
		rx_mark,
		rx_finish
	} rx_state_t;

endpackage

`default_nettype wire

//--- src/uart_string_handle.sv
`timescale 1ns/1ps
`default_nettype none

// uart string handler.
// frames an outgoing string as "&&" payload "&&", and hunts the
// incoming byte stream for a framed string to collect.

module uart_string_handle (
	input  wire                                sys_clk,
	input  wire                                sys_rst_n,
	input  wire  [uart_str_pkg::max_len*8-1:0] tx_string,
	input  wire  [uart_str_pkg::len_w-1:0]     tx_length,
	input  wire                                tx_req,
	output logic                               tx_busy,
	output logic                               tx_done,
	output logic [uart_str_pkg::max_len*8-1:0] rx_string,
	output logic [uart_str_pkg::len_w-1:0]     rx_length,
	output logic                               rx_busy,
	output logic                               rx_done,
	output logic [7:0]                         byte_tx_data,
	output logic                               byte_tx_start,
	input  wire                                byte_tx_done,
	input  wire  [7:0]                         byte_rx_data,
	input  wire                                byte_rx_valid
);

	import uart_str_pkg::*;

	tx_state_t                tx_state;
	logic [max_len*8-1:0]     tx_buf;
	logic [len_w-1:0]         tx_len_q;
	logic [len_w-1:0]         tx_idx;
	logic [6:0]               tx_off;
	logic                     tx_accept;

	rx_state_t                rx_state;
	logic                     rx_is_mark;
	logic                     rx_is_data;
	logic [len_w-1:0]         rx_len_p1;
	logic [6:0]               rx_off;
	logic [6:0]               rx_off_p1;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// transmit side.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign tx_busy   = (tx_state != tx_idle) && (tx_state != tx_finish);
	assign tx_done   = (tx_state == tx_finish);
	assign tx_accept = !tx_busy && tx_req && (tx_length != '0);
	assign tx_off    = {tx_idx[3:0], 3'b000};

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			tx_state      <= tx_idle;
			tx_idx        <= '0;
			byte_tx_start <= 1'b0;
		end else begin
			byte_tx_start <= 1'b0;
			case (tx_state)
				tx_idle, tx_finish: begin
					if (tx_accept) begin
						tx_state      <= tx_open1;
						tx_idx        <= '0;
						byte_tx_start <= 1'b1;
					end else begin
						tx_state <= tx_idle;
					end
				end
				tx_open1: begin
					if (byte_tx_done) begin
						tx_state      <= tx_open2;
						byte_tx_start <= 1'b1;
					end
				end
				// first payload byte goes out after the second marker.
				tx_open2: begin
					if (byte_tx_done) begin
						tx_state      <= tx_body;
						tx_idx        <= tx_idx + 1'b1;
						byte_tx_start <= 1'b1;
					end
				end
				tx_body: begin
					if (byte_tx_done) begin
						byte_tx_start <= 1'b1;
						if (tx_idx == tx_len_q) begin
							tx_state <= tx_close1;
						end else begin
							tx_idx <= tx_idx + 1'b1;
						end
					end
				end
				tx_close1: begin
					if (byte_tx_done) begin
						tx_state      <= tx_close2;
						byte_tx_start <= 1'b1;
					end
				end
				tx_close2: begin
					if (byte_tx_done) begin
						tx_state <= tx_finish;
					end
				end
				default: tx_state <= tx_idle;
			endcase
		end
	end

	// next byte is chosen as the current one completes.
	always_ff @(posedge sys_clk) begin
		if (tx_accept) begin
			tx_buf       <= tx_string;
			tx_len_q     <= tx_length;
			byte_tx_data <= frame_mark;
		end else if (byte_tx_done) begin
			if ((tx_state == tx_open2) ||
			    ((tx_state == tx_body) && (tx_idx != tx_len_q))) begin
				byte_tx_data <= tx_buf[tx_off +: 8];
			end else begin
				byte_tx_data <= frame_mark;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// receive side.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign rx_is_mark = byte_rx_valid && (byte_rx_data == frame_mark);
	assign rx_is_data = byte_rx_valid && (byte_rx_data != frame_mark);
	assign rx_busy    = (rx_state == rx_open2) || (rx_state == rx_body) ||
	                    (rx_state == rx_mark);
	assign rx_done    = (rx_state == rx_finish);
	assign rx_len_p1  = rx_length + 1'b1;
	assign rx_off     = {rx_length[3:0], 3'b000};
	assign rx_off_p1  = {rx_len_p1[3:0], 3'b000};

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_state <= rx_hunt;
		end else begin
			case (rx_state)
				rx_hunt: begin
					if (rx_is_mark) begin
						rx_state <= rx_open2;
					end
				end
				rx_open2: begin
					if (rx_is_mark) begin
						rx_state <= rx_body;
					end else if (rx_is_data) begin
						rx_state <= rx_hunt;
					end
				end
				rx_body: begin
					if (rx_is_mark) begin
						rx_state <= rx_mark;
					end
				end
				// a second marker closes, anything else makes the "&" data.
				rx_mark: begin
					if (rx_is_mark) begin
						rx_state <= rx_finish;
					end else if (rx_is_data) begin
						rx_state <= rx_body;
					end
				end
				rx_finish: rx_state <= rx_hunt;
				default:   rx_state <= rx_hunt;
			endcase
		end
	end

	// bytes past max_len are dropped.
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_string <= '0;
			rx_length <= '0;
		end else if ((rx_state == rx_open2) && rx_is_mark) begin
			rx_string <= '0;
			rx_length <= '0;
		end else if ((rx_state == rx_body) && rx_is_data) begin
			if (rx_length != len_w'(max_len)) begin
				rx_string[rx_off +: 8] <= byte_rx_data;
				rx_length              <= rx_len_p1;
			end
		end else if ((rx_state == rx_mark) && rx_is_data) begin
			if (rx_len_p1 < len_w'(max_len)) begin
				rx_string[rx_off +: 8]    <= frame_mark;
				rx_string[rx_off_p1 +: 8] <= byte_rx_data;
				rx_length                 <= rx_length + 2'd2;
			end else if (rx_length != len_w'(max_len)) begin
				rx_string[rx_off +: 8] <= frame_mark;
				rx_length              <= rx_len_p1;
			end
		end
	end

	// the last closing marker leads to exactly one done pulse.
	a_tx_done_once: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(tx_state == tx_close2) && byte_tx_done |=> tx_done ##1 !tx_done);

	a_rx_done_once: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_done |=> !rx_done);

	a_rx_len_max: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_length <= len_w'(max_len));

endmodule

`default_nettype wire

//--- uart_str_link.f
src/uart_str_pkg.sv
src/uart_baud_timer.sv
src/uart_byte_tx.sv
src/uart_byte_rx.sv
src/uart_string_handle.sv
src/uart_str_link.sv
verif/tb_uart_str_link.sv

//--- verif/tb_uart_str_link.sv
`timescale 1ns/1ps
`default_nettype none

// testbench for the uart string link.
// loops the line back or injects serial bytes, and checks the framed
// strings against a model of the link.

module tb_uart_str_link;

	import uart_str_pkg::*;

	localparam int done_timeout = 4000;

	logic                 sys_clk;
	logic                 sys_rst_n;
	logic [max_len*8-1:0] tx_string;
	logic [len_w-1:0]     tx_length;
	logic                 tx_req;
	wire                  tx_busy;
	wire                  tx_done;
	wire  [max_len*8-1:0] rx_string;
	wire  [len_w-1:0]     rx_length;
	wire                  rx_busy;
	wire                  rx_done;
	wire                  uart_rx;
	wire                  uart_tx;
	logic                 loopback;
	logic                 inj_line;

	// model: expected strings in sending order, and bytes seen on uart_tx.
	logic [max_len*8-1:0] exp_str_q[$];
	logic [len_w-1:0]     exp_len_q[$];
	logic [7:0]           mon_q[$];
	logic                 mon_active;
	int                   mon_phase;
	logic [7:0]           mon_shift;
	int                   tx_done_cnt;
	int                   rx_done_cnt;
	logic                 hold_check;
	logic [max_len*8-1:0] held_string;
	logic [len_w-1:0]     held_length;

	assign uart_rx = loopback ? uart_tx : inj_line;

	uart_str_link uart_str_link_inst (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.tx_string (tx_string),
		.tx_length (tx_length),
		.tx_req    (tx_req),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.rx_string (rx_string),
		.rx_length (rx_length),
		.rx_busy   (rx_busy),
		.rx_done   (rx_done),
		.uart_rx   (uart_rx),
		.uart_tx   (uart_tx)
	);

	always #10 sys_clk = ~sys_clk;

	task automatic report_error(input string what);
		$display("%s", what);
		$display("Test failed");
		$fatal(1);
	endtask

	function automatic logic [7:0] random_data_byte();
		logic [7:0] b;
		b = 8'($urandom);
		while (b == frame_mark) begin
			b = 8'($urandom);
		end
		return b;
	endfunction

	// bytes above len are garbage, the link must not send them.
	function automatic logic [max_len*8-1:0] random_string(input int len);
		logic [max_len*8-1:0] s;
		for (int i = 0; i < max_len; i++) begin
			if (i < len) begin
				s[8*i +: 8] = random_data_byte();
			end else begin
				s[8*i +: 8] = 8'($urandom);
			end
		end
		return s;
	endfunction

	function automatic logic [max_len*8-1:0] keep_bytes(input logic [max_len*8-1:0] s,
		input int len);
		logic [max_len*8-1:0] r;
		r = '0;
		for (int i = 0; i < len; i++) begin
			r[8*i +: 8] = s[8*i +: 8];
		end
		return r;
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// line monitor, done counters and result hold check.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// samples fall half a bit after each bit start.
	always @(negedge sys_clk) begin
		if (!sys_rst_n) begin
			mon_active = 1'b0;
		end else if (!mon_active) begin
			if (!uart_tx) begin
				mon_active = 1'b1;
				mon_phase  = 0;
			end
		end else begin
			mon_phase = mon_phase + 1;
			if (mon_phase % clks_per_bit == clks_per_bit / 2) begin
				case (mon_phase / clks_per_bit)
					0: assert (!uart_tx) else report_error("start bit on uart_tx went high");
					9: begin
						assert (uart_tx) else report_error("stop bit on uart_tx was low");
						mon_q.push_back(mon_shift);
						mon_active = 1'b0;
					end
					default: mon_shift = {uart_tx, mon_shift[7:1]};
				endcase
			end
		end
	end

	always @(negedge sys_clk) begin
		if (tx_done) begin
			tx_done_cnt = tx_done_cnt + 1;
		end
		if (hold_check) begin
			assert (rx_length == held_length) else report_error($sformatf(
				"MISMATCH rx_length: expected %h, got %h", held_length, rx_length));
			assert (rx_string == held_string) else report_error($sformatf(
				"MISMATCH rx_string: expected %h, got %h", held_string, rx_string));
		end
		if (rx_done) begin
			rx_done_cnt = rx_done_cnt + 1;
			held_string = rx_string;
			held_length = rx_length;
			hold_check  = 1'b1;
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus and checks.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic wait_done_pulses(input int tx_target, input int rx_target);
		int n;
		n = 0;
		while ((tx_done_cnt < tx_target || rx_done_cnt < rx_target) && n < done_timeout) begin
			@(posedge sys_clk);
			n++;
		end
		assert (tx_done_cnt >= tx_target && rx_done_cnt >= rx_target)
			else report_error("timed out waiting for tx_done or rx_done");
	endtask

	task automatic check_rx_result();
		logic [max_len*8-1:0] exp_str;
		logic [len_w-1:0]     exp_len;
		exp_str = exp_str_q.pop_front();
		exp_len = exp_len_q.pop_front();
		assert (held_length == exp_len) else report_error($sformatf(
			"MISMATCH rx_length: expected %h, got %h", exp_len, held_length));
		assert (held_string == exp_str) else report_error($sformatf(
			"MISMATCH rx_string: expected %h, got %h", exp_str, held_string));
	endtask

	task automatic check_tx_frame(input logic [max_len*8-1:0] s, input int len);
		logic [7:0] exp;
		assert (mon_q.size() == len + 4) else report_error($sformatf(
			"MISMATCH uart_tx byte count: expected %h, got %h", len + 4, mon_q.size()));
		for (int i = 0; i < len + 4; i++) begin
			if (i < 2 || i >= len + 2) begin
				exp = frame_mark;
			end else begin
				exp = s[8*(i-2) +: 8];
			end
			assert (mon_q[i] == exp) else report_error($sformatf(
				"MISMATCH uart_tx byte %0d: expected %h, got %h", i, exp, mon_q[i]));
		end
		mon_q.delete();
	endtask

	// with disturb set a second request comes while busy and must be ignored.
	task automatic send_loopback(input logic [max_len*8-1:0] s, input int len,
		input bit disturb, input logic [max_len*8-1:0] other);
		int tx_base;
		int rx_base;
		int n;
		tx_base = tx_done_cnt;
		rx_base = rx_done_cnt;
		exp_str_q.push_back(keep_bytes(s, len));
		exp_len_q.push_back(len_w'(len));
		mon_q.delete();
		@(posedge sys_clk);
		#2;
		hold_check = 1'b0;
		tx_string  = s;
		tx_length  = len_w'(len);
		tx_req     = 1'b1;
		@(posedge sys_clk);
		#2;
		tx_req = 1'b0;
		if (disturb) begin
			n = 0;
			while (!tx_busy && n < 16) begin
				@(negedge sys_clk);
				n++;
			end
			assert (tx_busy) else report_error("tx_busy did not rise after a request");
			@(posedge sys_clk);
			#2;
			tx_string = other;
			tx_length = len_w'(max_len);
			tx_req    = 1'b1;
			@(posedge sys_clk);
			#2;
			tx_req = 1'b0;
		end
		wait_done_pulses(tx_base + 1, rx_base + 1);
		repeat (clks_per_bit * 12) @(posedge sys_clk);
		assert (tx_done_cnt == tx_base + 1) else report_error($sformatf(
			"MISMATCH tx_done count: expected %h, got %h", tx_base + 1, tx_done_cnt));
		assert (rx_done_cnt == rx_base + 1) else report_error($sformatf(
			"MISMATCH rx_done count: expected %h, got %h", rx_base + 1, rx_done_cnt));
		check_tx_frame(s, len);
		check_rx_result();
	endtask

	task automatic send_serial_byte(input logic [7:0] b);
		logic [9:0] bits;
		bits = {1'b1, b, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(posedge sys_clk);
			#2;
			inj_line = bits[i];
			repeat (clks_per_bit - 1) @(posedge sys_clk);
		end
	endtask

	task automatic inject_frame(input logic [max_len*8-1:0] s, input int len);
		int rx_base;
		rx_base = rx_done_cnt;
		exp_str_q.push_back(keep_bytes(s, len));
		exp_len_q.push_back(len_w'(len));
		@(posedge sys_clk);
		#2;
		hold_check = 1'b0;
		send_serial_byte(frame_mark);
		send_serial_byte(frame_mark);
		// both opening markers are in, so the receiver is collecting.
		@(negedge sys_clk);
		assert (rx_busy) else report_error("rx_busy is low after an opening marker pair");
		for (int i = 0; i < len; i++) begin
			send_serial_byte(s[8*i +: 8]);
		end
		send_serial_byte(frame_mark);
		send_serial_byte(frame_mark);
		wait_done_pulses(tx_done_cnt, rx_base + 1);
		check_rx_result();
	endtask

	initial begin
		int                   len;
		int                   pos;
		int                   rx_base;
		logic [max_len*8-1:0] s;
		sys_clk     = 1'b0;
		sys_rst_n   = 1'b0;
		tx_string   = '0;
		tx_length   = '0;
		tx_req      = 1'b0;
		loopback    = 1'b1;
		inj_line    = 1'b1;
		mon_active  = 1'b0;
		mon_phase   = 0;
		mon_shift   = '0;
		tx_done_cnt = 0;
		rx_done_cnt = 0;
		hold_check  = 1'b0;
		held_string = '0;
		held_length = '0;
		void'($urandom(32'h08df785e));
		repeat (4) @(posedge sys_clk);
		#2;
		sys_rst_n = 1'b1;

		@(negedge sys_clk);
		assert (uart_tx === 1'b1) else report_error($sformatf(
			"MISMATCH uart_tx: expected 1, got %h", uart_tx));
		assert (!tx_busy && !tx_done && !rx_busy && !rx_done)
			else report_error("a handshake output is high after reset");
		assert (rx_length == '0 && rx_string == '0)
			else report_error("rx_string or rx_length is not zero after reset");

		for (int k = 0; k < 20; k++) begin
			len = 1 + int'($urandom_range(max_len - 1, 0));
			send_loopback(random_string(len), len, 1'b0, '0);
		end

		// a zero length request is never taken.
		@(posedge sys_clk);
		#2;
		tx_length = '0;
		tx_req    = 1'b1;
		@(posedge sys_clk);
		#2;
		tx_req = 1'b0;
		repeat (clks_per_bit * 4) begin
			@(negedge sys_clk);
			assert (!tx_busy && uart_tx)
				else report_error("a zero length request started a frame");
		end
		len = 1 + int'($urandom_range(max_len - 1, 0));
		send_loopback(random_string(len), len, 1'b1, random_string(max_len));

		// noise that must not open a frame, then a real frame.
		@(posedge sys_clk);
		#2;
		loopback = 1'b0;
		rx_base  = rx_done_cnt;
		for (int k = 0; k < 3; k++) begin
			send_serial_byte(random_data_byte());
		end
		send_serial_byte(frame_mark);
		send_serial_byte(random_data_byte());
		repeat (clks_per_bit) @(posedge sys_clk);
		assert (rx_done_cnt == rx_base) else report_error("noise bytes produced rx_done");
		@(negedge sys_clk);
		assert (!rx_busy) else report_error("rx_busy stayed high after noise bytes");
		len = 1 + int'($urandom_range(max_len - 1, 0));
		inject_frame(random_string(len), len);

		// one lone marker kept inside the payload.
		len = 3 + int'($urandom_range(max_len - 3, 0));
		pos = 1 + int'($urandom_range(len - 3, 0));
		s   = random_string(len);
		s[8*pos +: 8] = frame_mark;
		inject_frame(s, len);

		repeat (clks_per_bit * 4) @(posedge sys_clk);
		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire
